// ==== hdl/pifo_cmd_decode.sv ====
`timescale 1ns/1ps

module pifo_cmd_decode import pifo_ctrl_pkg::*; #(
    parameter int NUM_LEVELS = 4
) (
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  node_cmd_t i_cmd,
    output logic      o_read,
    output node_ctx_t o_ctx
);

    localparam logic [LEVEL_W-1:0] LEVEL_MASK = LEVEL_W'(NUM_LEVELS - 1);
    localparam node_ctx_t CTX_IDLE = '{state: ST_IDLE, default: '0};

    node_ctx_t ctx_q;
    logic      accept;      // Free to take a new command
    logic      single_cmd;  // Exactly one of push and pop

    // Level field must cover every level of the tree
    if ((NUM_LEVELS < 2) || (NUM_LEVELS > (1 << LEVEL_W)) ||
        ((NUM_LEVELS & (NUM_LEVELS - 1)) != 0)) begin : g_bad_levels
        $error("NUM_LEVELS must be a power of two between 2 and 2**LEVEL_W");
    end

    assign accept     = (ctx_q.state != ST_POP);
    assign single_cmd = i_cmd.push ^ i_cmd.pop;

    // ------------------------------------------------------------------------
    // Controller state and latched node context
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ctx_q <= CTX_IDLE;
        end else if (!accept) begin
            ctx_q.state <= ST_WB;  // Keep addr and level for the final write
        end else if (single_cmd) begin
            ctx_q.addr  <= i_cmd.addr;
            ctx_q.level <= i_cmd.level & LEVEL_MASK;
            if (i_cmd.push) begin
                ctx_q.state <= ST_PUSH;
                ctx_q.data  <= i_cmd.data;
            end else begin
                ctx_q.state <= ST_POP;
                ctx_q.data  <= '0;
            end
        end else begin
            ctx_q <= CTX_IDLE;     // Idle or push+pop together
        end
    end

    // Node word is fetched while the command is being latched
    assign o_read = single_cmd & accept;
    assign o_ctx  = ctx_q;

endmodule

// ==== hdl/pifo_ctrl_pkg.sv ====
package pifo_ctrl_pkg;

    import pifo_slot_pkg::*;

    localparam int LEVEL_W = 2;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_PUSH = 2'b01,
        ST_POP  = 2'b11,
        ST_WB   = 2'b10   // Second write of a pop with the child data merged
    } ctrl_state_e;

    // Command from the parent node
    typedef struct packed {
        logic               push;
        logic               pop;
        prio_t              data;
        logic [ADDR_W-1:0]  addr;
        logic [LEVEL_W-1:0] level;
    } node_cmd_t;

    typedef struct packed {
        ctrl_state_e        state;
        prio_t              data;   // Push value or zero on a pop
        logic [ADDR_W-1:0]  addr;
        logic [LEVEL_W-1:0] level;
    } node_ctx_t;

endpackage

// ==== hdl/pifo_node_update.sv ====
`timescale 1ns/1ps

module pifo_node_update
    import pifo_slot_pkg::*;
    import pifo_ctrl_pkg::*;
#(
    parameter int NUM_LEVELS = 4
) (
    input  node_ctx_t  i_ctx,
    input  node_word_t i_word,
    input  slot_pick_t i_pick,
    input  prio_t      i_child_pop_data,
    output sram_wr_t   o_wr,
    output child_req_t o_child,
    output prio_t      o_pop_data
);

    slot_t cnt_slot;   // Slot chosen for a push
    slot_t prio_slot;  // Slot chosen for a pop
    logic  is_leaf;

    // Children of a node sit at 8*addr + slot on the next level
    function automatic logic [ADDR_W-1:0] child_addr(
        input logic [ADDR_W-1:0]     addr,
        input logic [SLOT_IDX_W-1:0] slot
    );
        return ADDR_W'({addr, slot});
    endfunction

    assign cnt_slot  = i_word[i_pick.min_cnt_slot];
    assign prio_slot = i_word[i_pick.min_prio_slot];
    assign is_leaf   = (i_ctx.level == LEVEL_W'(NUM_LEVELS - 1));

    // ------------------------------------------------------------------------
    // Write word, child request and pop result
    // ------------------------------------------------------------------------
    always_comb begin
        node_word_t new_word;

        new_word   = i_word;
        o_wr       = '0;
        o_child    = '0;
        o_pop_data = PRIO_EMPTY;

        unique case (i_ctx.state)
            ST_PUSH: begin
                new_word[i_pick.min_cnt_slot].cnt = cnt_slot.cnt + 1'b1;
                o_child.addr = child_addr(i_ctx.addr, i_pick.min_cnt_slot);
                if (cnt_slot.prio == PRIO_EMPTY) begin
                    new_word[i_pick.min_cnt_slot].prio = i_ctx.data;
                end else begin
                    o_child.push = !is_leaf;  // Leaf has nowhere to send it
                    if (i_ctx.data < cnt_slot.prio) begin
                        new_word[i_pick.min_cnt_slot].prio = i_ctx.data;
                        o_child.data = cnt_slot.prio;   // Displaced value moves down
                    end else begin
                        o_child.data = i_ctx.data;
                    end
                end
                o_wr.write = 1'b1;
                o_wr.word  = new_word;
            end

            ST_POP, ST_WB: begin
                o_pop_data = prio_slot.prio;
                // The child's refill value is final only in ST_WB
                new_word[i_pick.min_prio_slot].prio = i_child_pop_data;
                if (prio_slot.cnt != '0) begin
                    new_word[i_pick.min_prio_slot].cnt = prio_slot.cnt - 1'b1;
                end
                o_child.pop  = (i_ctx.state == ST_POP) && !is_leaf;
                o_child.addr = child_addr(i_ctx.addr, i_pick.min_prio_slot);
                o_wr.write   = 1'b1;
                o_wr.word    = new_word;
            end

            default: begin
                // Idle, nothing to write
            end
        endcase
    end

endmodule

// ==== hdl/pifo_slot_pkg.sv ====
package pifo_slot_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int PRIO_W     = 16;  // Priority payload
    localparam int CNT_W      = 10;  // Sub-tree occupancy
    localparam int SLOTS      = 8;
    localparam int SLOT_IDX_W = 3;
    localparam int ADDR_W     = 9;   // Node address within a level

    typedef logic [PRIO_W-1:0] prio_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    // Empty slot marker
    localparam prio_t PRIO_EMPTY = '1;

    // ------------------------------------------------------------------------
    // Node storage
    // ------------------------------------------------------------------------
    typedef struct packed {
        cnt_t  cnt;   // Entries held in this slot and below it
        prio_t prio;
    } slot_t;

    typedef slot_t [SLOTS-1:0] node_word_t;  // Slot 0 in the low bits

    // Request to the node one level down
    typedef struct packed {
        logic              push;
        logic              pop;
        prio_t             data;
        logic [ADDR_W-1:0] addr;
    } child_req_t;

    typedef struct packed {
        logic       write;
        node_word_t word;
    } sram_wr_t;

    typedef struct packed {
        logic [SLOT_IDX_W-1:0] min_cnt_slot;   // Push target
        logic [SLOT_IDX_W-1:0] min_prio_slot;  // Pop source
    } slot_pick_t;

endpackage

// ==== hdl/pifo_slot_select.sv ====
`timescale 1ns/1ps

module pifo_slot_select import pifo_slot_pkg::*; (
    input  node_word_t i_word,
    output slot_pick_t o_pick
);

    // ------------------------------------------------------------------------
    // Push goes to the least occupied sub-tree
    // ------------------------------------------------------------------------
    always_comb begin
        cnt_t best_cnt;

        best_cnt            = i_word[0].cnt;
        o_pick.min_cnt_slot = '0;
        for (int i = 1; i < SLOTS; i++) begin
            // Strict compare keeps the lower index on a tie
            if (i_word[i].cnt < best_cnt) begin
                best_cnt            = i_word[i].cnt;
                o_pick.min_cnt_slot = SLOT_IDX_W'(i);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Pop comes from the smallest priority
    // ------------------------------------------------------------------------
    always_comb begin
        prio_t best_prio;

        best_prio            = i_word[0].prio;
        o_pick.min_prio_slot = '0;
        for (int i = 1; i < SLOTS; i++) begin
            if (i_word[i].prio < best_prio) begin
                best_prio            = i_word[i].prio;
                o_pick.min_prio_slot = SLOT_IDX_W'(i);
            end
        end
    end

endmodule

// ==== hdl/pifo_sram_node.sv ====
`timescale 1ns/1ps

module pifo_sram_node
    import pifo_slot_pkg::*;
    import pifo_ctrl_pkg::*;
#(
    parameter int NUM_LEVELS = 4
) (
    input  logic               i_clk,
    input  logic               i_arst_n,
    // Parent side
    input  node_cmd_t          i_cmd,
    output prio_t              o_pop_data,
    // Child side
    output child_req_t         o_child,
    input  prio_t              i_child_pop_data,
    output logic [LEVEL_W-1:0] o_level,
    // SRAM side
    output logic               o_read,
    output logic [ADDR_W-1:0]  o_read_addr,
    input  node_word_t         i_read_data,
    output sram_wr_t           o_wr,
    output logic [ADDR_W-1:0]  o_write_addr
);

    node_ctx_t  ctx;
    slot_pick_t pick;

    // ------------------------------------------------------------------------
    // Decode, select and result stages
    // ------------------------------------------------------------------------
    pifo_cmd_decode #(
        .NUM_LEVELS (NUM_LEVELS)
    ) u_decode (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_cmd    (i_cmd),
        .o_read   (o_read),
        .o_ctx    (ctx)
    );

    pifo_slot_select u_select (
        .i_word (i_read_data),
        .o_pick (pick)
    );

    pifo_node_update #(
        .NUM_LEVELS (NUM_LEVELS)
    ) u_update (
        .i_ctx            (ctx),
        .i_word           (i_read_data),
        .i_pick           (pick),
        .i_child_pop_data (i_child_pop_data),
        .o_wr             (o_wr),
        .o_child          (o_child),
        .o_pop_data       (o_pop_data)
    );

    assign o_read_addr  = i_cmd.addr;  // Read with the incoming command
    assign o_write_addr = ctx.addr;    // Write back to the latched node
    assign o_level      = ctx.level + 1'b1;

endmodule

// ==== src.f ====
hdl/pifo_slot_pkg.sv
hdl/pifo_ctrl_pkg.sv
hdl/pifo_cmd_decode.sv
hdl/pifo_slot_select.sv
hdl/pifo_node_update.sv
hdl/pifo_sram_node.sv
verif/pifo_node_sva.sv
verif/tb_pifo_sram_node.sv

// ==== verif/pifo_input.txt ====
# op(1 push, 2 pop, 3 both) value addr level child_pop_data
# exp_pop_data exp_child_strobe exp_child_data exp_child_addr, all hex
3 0abc 010 3 ffff ffff 0 0000 000
1 0500 010 3 ffff ffff 0 0000 080
1 0300 010 3 ffff ffff 0 0000 081
1 0700 010 3 ffff ffff 0 0000 082
1 0100 010 3 ffff ffff 0 0000 083
1 0900 010 3 ffff ffff 0 0000 084
1 0200 010 3 ffff ffff 0 0000 085
1 0800 010 3 ffff ffff 0 0000 086
1 0400 010 3 ffff ffff 0 0000 087
1 0050 010 3 ffff ffff 0 0500 080
2 0000 010 3 ffff 0050 0 0000 080
2 0000 010 3 ffff 0100 0 0000 083
1 0150 010 3 ffff ffff 0 0000 083
1 2000 001 0 ffff ffff 0 0000 008
1 1000 001 0 ffff ffff 0 0000 009
1 3000 001 0 ffff ffff 0 0000 00a
1 1800 001 0 ffff ffff 0 0000 00b
1 2800 001 0 ffff ffff 0 0000 00c
1 0800 001 0 ffff ffff 0 0000 00d
1 3800 001 0 ffff ffff 0 0000 00e
1 1400 001 0 ffff ffff 0 0000 00f
1 1200 001 0 ffff ffff 1 2000 008
1 3400 001 0 ffff ffff 1 3400 009
3 0001 001 0 ffff ffff 0 0000 000
2 0000 001 0 0900 0800 1 0000 00d
2 0000 001 0 ffff 0900 1 0000 00d
2 0000 001 0 3400 1000 1 0000 009
2 0000 030 2 ffff ffff 1 0000 180
1 0777 030 2 ffff ffff 0 0000 180

// ==== verif/pifo_node_sva.sv ====
`timescale 1ns/1ps

module pifo_node_sva
    import pifo_ctrl_pkg::*;
(
    input logic        i_clk,
    input logic        i_arst_n,
    input node_cmd_t   i_cmd,
    input ctrl_state_e i_state,
    input logic        i_read,
    input logic        i_write,
    input logic        i_child_push,
    input logic        i_child_pop
);

    // Cycle after an accepted pop belongs to the child read
    property no_cmd_in_pop;
        @(posedge i_clk) disable iff (!i_arst_n)
            (i_state == ST_POP) |-> !(i_cmd.push ^ i_cmd.pop);
    endproperty

    property quiet_in_reset;
        @(posedge i_clk)
            !i_arst_n |-> (i_state == ST_IDLE) && !i_read && !i_write &&
                          !i_child_push && !i_child_pop;
    endproperty

    property quiet_after_reset;
        @(posedge i_clk)
            $rose(i_arst_n) |-> (i_state == ST_IDLE) && !i_write &&
                                !i_child_push && !i_child_pop;
    endproperty

    // A write follows an accepted read by one cycle or is the pop writeback
    property no_write_in_idle;
        @(posedge i_clk) disable iff (!i_arst_n)
            i_write |-> (i_state != ST_IDLE) &&
                        ($past(i_read) || (i_state == ST_WB));
    endproperty

    a_no_cmd_in_pop: assert property (no_cmd_in_pop)
        else $error("command issued while the controller was in ST_POP");
    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("control strobe or state active during reset");
    a_quiet_after_reset: assert property (quiet_after_reset)
        else $error("control strobe or state active right after reset");
    a_no_write_in_idle: assert property (no_write_in_idle)
        else $error("SRAM write in ST_IDLE or without an accepted command");

endmodule

// ==== verif/tb_pifo_sram_node.sv ====
`timescale 1ns/1ps

module tb_pifo_sram_node
    import pifo_slot_pkg::*;
    import pifo_ctrl_pkg::*;
();

    localparam int NUM_LEVELS = 4;
    localparam int WAIT_LIMIT = 8;          // Cycles allowed for any wait
    localparam int SRAM_DEPTH = 1 << ADDR_W;

    localparam logic [3:0] OP_PUSH = 4'h1;
    localparam logic [3:0] OP_BOTH = 4'h3;

    localparam slot_t      EMPTY_SLOT = '{cnt: '0, prio: PRIO_EMPTY};
    localparam node_word_t EMPTY_NODE = {SLOTS{EMPTY_SLOT}};

    // One line of the stimulus file
    typedef struct packed {
        logic [3:0]         op;
        prio_t              value;
        logic [ADDR_W-1:0]  addr;
        logic [LEVEL_W-1:0] level;
        prio_t              child_data;
        prio_t              exp_pop;
        logic               exp_strobe;    // Child push or pop expected
        prio_t              exp_child_data;
        logic [ADDR_W-1:0]  exp_child_addr;
    } vector_t;

    logic               i_clk;
    logic               i_arst_n;
    node_cmd_t          cmd;
    prio_t              child_pop_data;
    prio_t              pop_data;
    child_req_t         child;
    logic [LEVEL_W-1:0] level;
    logic               read;
    logic [ADDR_W-1:0]  read_addr;
    logic [ADDR_W-1:0]  write_addr;
    node_word_t         read_data;
    sram_wr_t           wr;

    node_word_t sram    [SRAM_DEPTH];
    node_word_t ref_mem [SRAM_DEPTH];   // Expected node contents
    int   errors;
    int   checks;
    int   vectors;
    logic timed_out;

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // SRAM with registered read data
    always @(posedge i_clk) begin
        if (read) read_data <= sram[read_addr];
        if (wr.write) sram[write_addr] <= wr.word;
    end

    pifo_sram_node #(
        .NUM_LEVELS (NUM_LEVELS)
    ) dut0 (
        .i_clk            (i_clk),
        .i_arst_n         (i_arst_n),
        .i_cmd            (cmd),
        .o_pop_data       (pop_data),
        .o_child          (child),
        .i_child_pop_data (child_pop_data),
        .o_level          (level),
        .o_read           (read),
        .o_read_addr      (read_addr),
        .i_read_data      (read_data),
        .o_wr             (wr),
        .o_write_addr     (write_addr)
    );

    bind pifo_sram_node pifo_node_sva u_sva (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_cmd        (i_cmd),
        .i_state      (ctx.state),
        .i_read       (o_read),
        .i_write      (o_wr.write),
        .i_child_push (o_child.push),
        .i_child_pop  (o_child.pop)
    );

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_prio(input string name, input prio_t got, input prio_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_child(input string name, input child_req_t got,
                               input child_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input node_word_t got,
                              input node_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_level(input logic [LEVEL_W-1:0] got, input logic [LEVEL_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] o_level: got %h, expected %h", got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference node behavior
    // ------------------------------------------------------------------------
    function automatic node_word_t model_push(input node_word_t w, input prio_t v);
        int s;
        s = 0;
        for (int i = 1; i < SLOTS; i++) begin
            if (w[i].cnt < w[s].cnt) s = i;   // Lowest index wins a tie
        end
        if (w[s].prio == PRIO_EMPTY || v < w[s].prio) w[s].prio = v;
        w[s].cnt = w[s].cnt + 1;
        return w;
    endfunction

    function automatic node_word_t model_pop(input node_word_t w, input prio_t refill);
        int s;
        s = 0;
        for (int i = 1; i < SLOTS; i++) begin
            if (w[i].prio < w[s].prio) s = i;
        end
        w[s].prio = refill;
        if (w[s].cnt != 0) w[s].cnt = w[s].cnt - 1;
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // Drive on the falling edge and sample 1 ns later
    // ------------------------------------------------------------------------
    task automatic finish_run();
        $display("Checks %0d, vectors %0d, errors %0d", checks, vectors, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic idle_cycle();
        @(negedge i_clk);
        cmd = '0;
        #1;
    endtask

    // Child answers in the cycle after its pop strobe
    task automatic child_return(input prio_t data);
        @(negedge i_clk);
        cmd            = '0;
        child_pop_data = data;
        #1;
    endtask

    task automatic drive_cmd(input vector_t v);
        @(negedge i_clk);
        cmd.push       = (v.op == OP_PUSH) || (v.op == OP_BOTH);
        cmd.pop        = (v.op != OP_PUSH);
        cmd.data       = v.value;
        cmd.addr       = v.addr;
        cmd.level      = v.level;
        child_pop_data = ~v.child_data;   // Child bus not valid yet
        #1;
    endtask

    task automatic wait_write(input logic level_wanted, input string what,
                              output int cycles);
        cycles = 0;
        while (wr.write !== level_wanted && cycles < WAIT_LIMIT) begin
            idle_cycle();
            cycles++;
        end
        if (wr.write !== level_wanted) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    task automatic run_vector(input vector_t v);
        node_word_t exp_word;
        child_req_t exp_child;
        int         lat;
        exp_word  = ref_mem[v.addr];
        exp_child = '{push: 1'b0, pop: 1'b0, data: v.exp_child_data, addr: v.exp_child_addr};
        drive_cmd(v);
        if (v.op == OP_BOTH) begin
            check_flag("o_read", read, 1'b0);
            repeat (3) begin
                idle_cycle();
                check_flag("o_wr.write", wr.write, 1'b0);
            end
        end else begin
            check_flag("o_read", read, 1'b1);
            check_addr("o_read_addr", read_addr, v.addr);
            wait_write(1'b1, "the SRAM write of a command", lat);
            if (timed_out) return;
            if (lat != 1) begin
                errors++;
                $display("SRAM write came %0d cycles after the command, expected 1", lat);
            end
            check_prio("o_pop_data", pop_data, v.exp_pop);
            check_addr("o_write_addr", write_addr, v.addr);
            check_level(level, LEVEL_W'(v.level + 1));
            if (v.op == OP_PUSH) begin
                exp_word       = model_push(exp_word, v.value);
                exp_child.push = v.exp_strobe;
                check_child("o_child", child, exp_child);
            end else begin
                exp_word      = model_pop(exp_word, v.child_data);
                exp_child.pop = v.exp_strobe;
                check_child("o_child", child, exp_child);
                child_return(v.child_data);     // Writeback cycle
                check_flag("o_wr.write", wr.write, 1'b1);
                check_prio("o_pop_data", pop_data, v.exp_pop);
                exp_child.pop = 1'b0;
                check_child("o_child", child, exp_child);
            end
            check_word("o_wr.word", wr.word, exp_word);
            wait_write(1'b0, "the controller to return to idle", lat);
            if (timed_out) return;
        end
        ref_mem[v.addr] = exp_word;
        check_word("sram", sram[v.addr], exp_word);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [9];
        vector_t     v;

        errors         = 0;
        checks         = 0;
        vectors        = 0;
        timed_out      = 1'b0;
        i_arst_n       = 1'b0;
        cmd            = '0;
        child_pop_data = PRIO_EMPTY;
        read_data      = EMPTY_NODE;
        for (int a = 0; a < SRAM_DEPTH; a++) begin
            sram[a]    = EMPTY_NODE;
            ref_mem[a] = EMPTY_NODE;
        end
        repeat (4) @(negedge i_clk);
        i_arst_n = 1'b1;

        idle_cycle();
        check_flag("o_read", read, 1'b0);
        check_flag("o_wr.write", wr.write, 1'b0);
        check_flag("o_child.push", child.push, 1'b0);
        check_flag("o_child.pop", child.pop, 1'b0);

        fd = $fopen("verif/pifo_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file verif/pifo_input.txt");
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (n == 9) begin
                        v = '{op: f[0][3:0], value: f[1][15:0], addr: f[2][ADDR_W-1:0],
                              level: f[3][LEVEL_W-1:0], child_data: f[4][15:0],
                              exp_pop: f[5][15:0], exp_strobe: f[6][0],
                              exp_child_data: f[7][15:0], exp_child_addr: f[8][ADDR_W-1:0]};
                        vectors++;
                        run_vector(v);
                    end else if (n > 0) begin
                        errors++;
                        $display("Malformed stimulus line: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
        if (vectors == 0) begin
            errors++;
            $display("No vectors were read from the stimulus file");
        end
        finish_run();
    end

endmodule
